/* filelist.f */
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/sync_fifo.sv
source/pc_generator.sv
source/instruction_aligner.sv
source/fetch_front_end.sv
tb/fetch_checker.sv
tb/tb_fetch_front_end.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch front end testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_front_end \
    -f filelist.f -o sim_fetch_front_end > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_fetch_front_end > sim.log 2>&1 ; cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation finished without failures"

/* source/fetch_front_end.sv */
// Top level of the instruction fetch front end, connecting PC generation, queues and aligner
`timescale 1ns/1ps
`default_nettype none

module fetch_front_end (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Redirects and back-pressure from the back end
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  fetch_pkg::fetch_addr_t  handler_pc_i,
    input  logic                    handler_return_i,
    input  fetch_pkg::fetch_addr_t  handler_return_pc_i,
    input  logic                    redirect_i,
    input  fetch_pkg::fetch_addr_t  redirect_target_i,
    input  logic                    stall_i,

    // Instruction memory
    output logic                    fetch_o,
    output fetch_pkg::fetch_addr_t  fetch_address_o,
    output logic                    invalidate_o,
    input  logic                    fetch_valid_i,
    input  rv_isa_pkg::instr_word_t fetch_instruction_i,

    // Aligned instruction stream
    output logic                    instr_valid_o,
    output rv_isa_pkg::instr_word_t instr_o,
    output fetch_pkg::fetch_addr_t  instr_pc_o,
    output logic                    instr_compressed_o
);

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    fetch_addr_t fetch_pc;
    fetch_addr_t head_pc;
    instr_word_t head_word;
    logic        addr_full;
    logic        word_empty;
    logic        aligner_pop;

    //==============================
    // PC generation
    //==============================

    pc_generator u_pc_generator (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .exception_i         ( exception_i         ),
        .interrupt_i         ( interrupt_i         ),
        .handler_pc_i        ( handler_pc_i        ),
        .handler_return_i    ( handler_return_i    ),
        .handler_return_pc_i ( handler_return_pc_i ),
        .redirect_i          ( redirect_i          ),
        .redirect_target_i   ( redirect_target_i   ),
        .queue_full_i        ( addr_full           ),
        .fetch_o             ( fetch_o             ),
        .fetch_address_o     ( fetch_address_o     ),
        .fetch_pc_o          ( fetch_pc            ),
        .invalidate_o        ( invalidate_o        )
    );

    //==============================
    // Outstanding fetch queues
    //==============================

    // The redirect fetch is issued in the flush cycle, so its address must survive
    sync_fifo #(
        .payload_t          ( fetch_addr_t      ),
        .DEPTH              ( FETCH_QUEUE_DEPTH ),
        .KEEP_PUSH_ON_FLUSH ( 1'b1              )
    ) addr_queue (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .flush_i     ( invalidate_o ),
        .push_i      ( fetch_o      ),
        .push_data_i ( fetch_pc     ),
        .pop_i       ( aligner_pop  ),
        .pop_data_o  ( head_pc      ),
        .empty_o     (              ),
        .full_o      ( addr_full    )
    );

    // A word arriving with the flush answers an old request and is dropped
    sync_fifo #(
        .payload_t          ( instr_word_t      ),
        .DEPTH              ( FETCH_QUEUE_DEPTH ),
        .KEEP_PUSH_ON_FLUSH ( 1'b0              )
    ) word_queue (
        .clk_i       ( clk_i               ),
        .rst_n_i     ( rst_n_i             ),
        .flush_i     ( invalidate_o        ),
        .push_i      ( fetch_valid_i       ),
        .push_data_i ( fetch_instruction_i ),
        .pop_i       ( aligner_pop         ),
        .pop_data_o  ( head_word           ),
        .empty_o     ( word_empty          ),
        .full_o      (                     )
    );

    //==============================
    // Alignment and output stage
    //==============================

    instruction_aligner u_instruction_aligner (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .flush_i            ( invalidate_o       ),
        .stall_i            ( stall_i            ),
        .word_empty_i       ( word_empty         ),
        .word_i             ( head_word          ),
        .word_pc_i          ( head_pc            ),
        .pop_o              ( aligner_pop        ),
        .instr_valid_o      ( instr_valid_o      ),
        .instr_o            ( instr_o            ),
        .instr_pc_o         ( instr_pc_o         ),
        .instr_compressed_o ( instr_compressed_o )
    );

endmodule : fetch_front_end

`default_nettype wire

/* source/fetch_pkg.sv */
// Fetch path constants and address type, imported by every module of the fetch front end
`default_nettype none

package fetch_pkg;

    //==============================
    // Addressing
    //==============================

    // Byte address width of the instruction space
    localparam int ADDR_WIDTH = 32;

    // Byte address of a fetch or of a single instruction
    typedef logic [ADDR_WIDTH-1:0] fetch_addr_t;

    // First fetch address after reset
    localparam fetch_addr_t RESET_PC = '0;

    // Address step between two memory words
    localparam int WORD_BYTES = 4;

    // Address step between two parcels inside a word
    localparam int HALF_BYTES = 2;

    //==============================
    // Queueing
    //==============================

    // Number of fetches that may be outstanding or waiting in the queues
    // Both queues use it, so a word always finds a slot
    localparam int FETCH_QUEUE_DEPTH = 4;

endpackage : fetch_pkg

`default_nettype wire

/* source/instruction_aligner.sv */
// Splits and fuses queued memory words into 16/32 bit instructions behind one output register
`timescale 1ns/1ps
`default_nettype none

module instruction_aligner (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    stall_i,

    // Heads of the word and address queues
    input  logic                    word_empty_i,
    input  rv_isa_pkg::instr_word_t word_i,
    input  fetch_pkg::fetch_addr_t  word_pc_i,
    output logic                    pop_o,

    // Registered output stage
    output logic                    instr_valid_o,
    output rv_isa_pkg::instr_word_t instr_o,
    output fetch_pkg::fetch_addr_t  instr_pc_o,
    output logic                    instr_compressed_o
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    // Upper parcel of the last popped word that still waits to be used
    logic        pending_valid;
    instr_half_t pending_half;
    fetch_addr_t pending_pc;

    instr_half_t low_half;
    instr_half_t high_half;
    fetch_addr_t word_base;
    fetch_addr_t upper_pc;
    logic        starts_upper;
    logic        low_compressed;
    logic        pending_compressed;

    // Instruction picked in this cycle
    logic        emit;
    instr_word_t emit_instr;
    fetch_addr_t emit_pc;
    logic        emit_compressed;
    logic        keep_upper;
    logic        drop_pending;

    assign low_half  = word_i[HALF_WIDTH-1:0];
    assign high_half = word_i[INSTR_WIDTH-1:HALF_WIDTH];
    assign word_base = word_pc_i & ~fetch_addr_t'(WORD_BYTES - 1);
    assign upper_pc  = word_base + fetch_addr_t'(HALF_BYTES);

    // Set when a halfword redirect target points at the upper parcel
    assign starts_upper       = (word_pc_i != word_base);
    assign low_compressed     = (low_half[1:0] != FULL_LENGTH_OPCODE);
    assign pending_compressed = (pending_half[1:0] != FULL_LENGTH_OPCODE);

    //==============================
    // Parcel selection
    //==============================

    always_comb begin
        emit            = 1'b0;
        emit_instr      = '0;
        emit_pc         = pending_pc;
        emit_compressed = 1'b0;
        pop_o           = 1'b0;
        keep_upper      = 1'b0;
        drop_pending    = 1'b0;
        if (!stall_i) begin
            if (pending_valid && pending_compressed) begin
                // Pending compressed parcel goes out without touching the queues
                emit            = 1'b1;
                emit_instr      = {{HALF_WIDTH{1'b0}}, pending_half};
                emit_compressed = 1'b1;
                drop_pending    = 1'b1;
            end else if (pending_valid) begin
                // Lower half of a 32 bit instruction waits for the next word
                if (!word_empty_i) begin
                    emit       = 1'b1;
                    emit_instr = {low_half, pending_half};
                    pop_o      = 1'b1;
                    keep_upper = 1'b1;
                end
            end else if (!word_empty_i) begin
                pop_o = 1'b1;
                if (starts_upper) begin
                    // The lower parcel lies before the target and is skipped
                    keep_upper = 1'b1;
                end else if (low_compressed) begin
                    emit            = 1'b1;
                    emit_instr      = {{HALF_WIDTH{1'b0}}, low_half};
                    emit_pc         = word_pc_i;
                    emit_compressed = 1'b1;
                    keep_upper      = 1'b1;
                end else begin
                    emit       = 1'b1;
                    emit_instr = word_i;
                    emit_pc    = word_pc_i;
                end
            end
        end
    end

    //==============================
    // Pending parcel and output stage
    //==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_valid <= 1'b0;
            instr_valid_o <= 1'b0;
        end else if (flush_i) begin
            pending_valid <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            if (keep_upper) begin
                pending_valid <= 1'b1;
            end else if (drop_pending) begin
                pending_valid <= 1'b0;
            end
            // Output holds while stalled
            if (!stall_i) begin
                instr_valid_o <= emit;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep_upper) begin
            pending_half <= high_half;
            pending_pc   <= upper_pc;
        end
        if (emit) begin
            instr_o            <= emit_instr;
            instr_pc_o         <= emit_pc;
            instr_compressed_o <= emit_compressed;
        end
    end

endmodule : instruction_aligner

`default_nettype wire

/* source/pc_generator.sv */
// Program counter and prioritized next fetch address selection for the fetch front end
`timescale 1ns/1ps
`default_nettype none

module pc_generator (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Redirect sources from the back end
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  fetch_pkg::fetch_addr_t handler_pc_i,
    input  logic                   handler_return_i,
    input  fetch_pkg::fetch_addr_t handler_return_pc_i,
    input  logic                   redirect_i,
    input  fetch_pkg::fetch_addr_t redirect_target_i,

    // Back-pressure from the address queue
    input  logic                   queue_full_i,

    // Fetch request towards memory and the address queue
    output logic                   fetch_o,
    output fetch_pkg::fetch_addr_t fetch_address_o,
    output fetch_pkg::fetch_addr_t fetch_pc_o,
    output logic                   invalidate_o
);

    import fetch_pkg::*;

    // Address of the next sequential word
    fetch_addr_t program_counter;
    logic        handler_entry;

    //==============================
    // Next fetch selection
    //==============================

    assign handler_entry = exception_i | interrupt_i;

    // Every redirect source throws away what is queued or in flight
    assign invalidate_o = handler_entry | handler_return_i | redirect_i;

    // Fixed priority, handler entry first and sequential fetch last
    always_comb begin
        if (handler_entry) begin
            fetch_pc_o = handler_pc_i;
        end else if (handler_return_i) begin
            fetch_pc_o = handler_return_pc_i;
        end else if (redirect_i) begin
            fetch_pc_o = redirect_target_i;
        end else begin
            fetch_pc_o = program_counter;
        end
    end

    // A redirect fetches at once since the flush empties the queue in the same edge
    assign fetch_o = invalidate_o | !queue_full_i;

    // Memory is word addressed, the halfword offset stays in fetch_pc_o
    assign fetch_address_o = fetch_pc_o & ~fetch_addr_t'(WORD_BYTES - 1);

    //==============================
    // Program counter register
    //==============================

    // After a halfword target the sequence goes on at the following word
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            program_counter <= RESET_PC;
        end else if (fetch_o) begin
            program_counter <= fetch_address_o + fetch_addr_t'(WORD_BYTES);
        end
    end

endmodule : pc_generator

`default_nettype wire

/* source/rv_isa_pkg.sv */
// RISC-V instruction word and parcel definitions, imported by the aligner and the testbench
`default_nettype none

package rv_isa_pkg;

    //==============================
    // Instruction widths
    //==============================

    // Width of a full instruction and of one memory word
    localparam int INSTR_WIDTH = 32;

    // Width of one instruction parcel
    // A compressed instruction occupies exactly one parcel
    localparam int HALF_WIDTH = 16;

    //==============================
    // Instruction types
    //==============================

    // One memory word as returned by the instruction memory
    // Also used for an aligned instruction at the output
    typedef logic [INSTR_WIDTH-1:0] instr_word_t;

    // One 16 bit parcel of the instruction stream
    typedef logic [HALF_WIDTH-1:0] instr_half_t;

    //==============================
    // Length encoding
    //==============================

    // The two lowest bits of the first parcel select the instruction length
    // Only this pattern marks a 32 bit instruction
    // Every other value marks a compressed instruction
    localparam logic [1:0] FULL_LENGTH_OPCODE = 2'b11;

endpackage : rv_isa_pkg

`default_nettype wire

/* source/sync_fifo.sv */
// Synchronous FIFO with a payload type parameter, used for the fetch address and word queues
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type         payload_t          = fetch_pkg::fetch_addr_t,
    parameter int unsigned DEPTH              = fetch_pkg::FETCH_QUEUE_DEPTH,
    // When set, a push in the flush cycle survives as the only entry
    parameter bit          KEEP_PUSH_ON_FLUSH = 1'b0
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     full_o
);

    // Pointers wrap on their own because DEPTH is a power of two
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    payload_t         storage [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;
    logic             flush_push;

    assign empty_o    = (count == '0);
    assign full_o     = (count == FULL_COUNT);
    assign pop_data_o = storage[rd_ptr];

    // A pop frees a slot in the same cycle, so push on full is fine then
    assign do_pop     = pop_i && !empty_o;
    assign do_push    = push_i && (!full_o || do_pop);
    assign flush_push = KEEP_PUSH_ON_FLUSH && push_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            // Flush wins over pop, the queue restarts at slot zero
            rd_ptr <= '0;
            wr_ptr <= flush_push ? PTR_W'(1) : '0;
            count  <= flush_push ? CNT_W'(1) : '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            if (flush_push) begin
                storage[0] <= push_data_i;
            end
        end else if (do_push) begin
            storage[wr_ptr] <= push_data_i;
        end
    end

endmodule : sync_fifo

`default_nettype wire

/* tb/fetch_checker.sv */
// Concurrent assertions on the fetch front end outputs, bound to the top level by the bind below
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    stall_i,
    input logic                    invalidate_i,
    input logic                    fetch_i,
    input fetch_pkg::fetch_addr_t  fetch_address_i,
    input logic                    instr_valid_i,
    input rv_isa_pkg::instr_word_t instr_i,
    input fetch_pkg::fetch_addr_t  instr_pc_i,
    input logic                    instr_compressed_i
);

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    // A stalled valid output keeps every field until the stall ends
    // A flush in that cycle is allowed to drop it
    output_held_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i && instr_valid_i && !invalidate_i |=>
            instr_valid_i && $stable(instr_i) && $stable(instr_pc_i) &&
            $stable(instr_compressed_i))
        else $error("Output stage changed while stalled");

    valid_low_after_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        invalidate_i |=> !instr_valid_i)
        else $error("Instruction valid one cycle after invalidate");

    // Compressed parcels leave raw in the low half
    compressed_upper_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i && instr_compressed_i |-> instr_i[INSTR_WIDTH-1:HALF_WIDTH] == '0)
        else $error("Compressed instruction with a nonzero upper half");

    fetch_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_i |-> (fetch_address_i & fetch_addr_t'(WORD_BYTES - 1)) == '0)
        else $error("Fetch address is not word aligned");

endmodule : fetch_checker

bind fetch_front_end fetch_checker u_fetch_checker (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .stall_i            ( stall_i            ),
    .invalidate_i       ( invalidate_o       ),
    .fetch_i            ( fetch_o            ),
    .fetch_address_i    ( fetch_address_o    ),
    .instr_valid_i      ( instr_valid_o      ),
    .instr_i            ( instr_o            ),
    .instr_pc_i         ( instr_pc_o         ),
    .instr_compressed_i ( instr_compressed_o )
);

`default_nettype wire

/* tb/tb_fetch_front_end.sv */
// Directed testbench for the fetch front end with a memory model and a reference walk of parcels
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front_end;

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    localparam logic [31:0] SEED            = 32'h1b2d8c2d;
    localparam int unsigned MAX_DELAY       = 3;
    localparam int unsigned INSTRS_PER_TEST = 24;
    localparam int unsigned NUM_TESTS       = 9;
    // Worst case per instruction is a full queue of slow responses
    // The factor of four leaves room for random stalls
    localparam int unsigned TIMEOUT_CYCLES  =
        NUM_TESTS * INSTRS_PER_TEST * (MAX_DELAY + FETCH_QUEUE_DEPTH) * 4;
    localparam fetch_addr_t HANDLER_PC      = 32'h0000_0800;
    localparam fetch_addr_t RETURN_PC       = 32'h0000_0640;

    logic        clk_i;
    logic        rst_n_i;
    logic        exception_i;
    logic        interrupt_i;
    fetch_addr_t handler_pc_i;
    logic        handler_return_i;
    fetch_addr_t handler_return_pc_i;
    logic        redirect_i;
    fetch_addr_t redirect_target_i;
    logic        stall_i;
    logic        fetch_o;
    fetch_addr_t fetch_address_o;
    logic        invalidate_o;
    logic        fetch_valid_i;
    instr_word_t fetch_instruction_i;
    logic        instr_valid_o;
    instr_word_t instr_o;
    fetch_addr_t instr_pc_o;
    logic        instr_compressed_o;

    // Memory model state and expected stream
    logic [31:0] rng_state;
    logic        mixed_mode;
    logic        tracking;
    int unsigned mem_cycle;
    fetch_addr_t pend_addr [$];
    int unsigned pend_due [$];
    fetch_addr_t exp_pc [$];
    instr_word_t exp_instr [$];
    logic        exp_compressed [$];

    fetch_front_end UUT (.*);

    always #2 clk_i = ~clk_i;

    //==============================
    // Helpers
    //==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Parcel content at a halfword address
    // Its low bits decide the instruction length
    function automatic instr_half_t parcel_at(input fetch_addr_t addr);
        logic [31:0] mix;
        logic [1:0]  low_bits;
        mix = addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
        if (!mixed_mode) begin
            // Every word starts a 32 bit instruction
            // Upper parcels are free data
            low_bits = addr[1] ? mix[1:0] : FULL_LENGTH_OPCODE;
        end else if ((((addr >> 1) * 7) % 5) < 2) begin
            low_bits = FULL_LENGTH_OPCODE;
        end else begin
            low_bits = {mix[2], 1'b0};
        end
        return {mix[17:4], low_bits};
    endfunction

    function automatic instr_word_t memory_word(input fetch_addr_t addr);
        return {parcel_at(addr + fetch_addr_t'(HALF_BYTES)), parcel_at(addr)};
    endfunction

    // First upper parcel from base on that starts a 32 bit or a compressed instruction
    function automatic fetch_addr_t find_halfword_target(input fetch_addr_t base,
                                                         input bit want_full);
        fetch_addr_t addr;
        instr_half_t parcel;
        addr   = base | fetch_addr_t'(HALF_BYTES);
        parcel = parcel_at(addr);
        while ((parcel[1:0] == FULL_LENGTH_OPCODE) != want_full) begin
            addr   = addr + fetch_addr_t'(WORD_BYTES);
            parcel = parcel_at(addr);
        end
        return addr;
    endfunction

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $realtime, what, got, want);
            stop_on_failure();
        end
    endtask

    // Reference walk over memory parcels from the start PC
    task automatic build_expected_stream(input fetch_addr_t start);
        fetch_addr_t pc;
        instr_half_t low;
        pc = start;
        exp_pc.delete();
        exp_instr.delete();
        exp_compressed.delete();
        repeat (INSTRS_PER_TEST) begin
            low = parcel_at(pc);
            exp_pc.push_back(pc);
            if (low[1:0] == FULL_LENGTH_OPCODE) begin
                exp_instr.push_back({parcel_at(pc + fetch_addr_t'(HALF_BYTES)), low});
                exp_compressed.push_back(1'b0);
                pc = pc + fetch_addr_t'(WORD_BYTES);
            end else begin
                exp_instr.push_back({16'h0000, low});
                exp_compressed.push_back(1'b1);
                pc = pc + fetch_addr_t'(HALF_BYTES);
            end
        end
        tracking = 1'b1;
    endtask

    // Runs until the monitor has seen the whole expected stream
    task automatic wait_stream(input bit random_stall);
        while (tracking) begin
            if (random_stall) begin
                stall_i = (next_random() % 8) < 3;
            end
            @(negedge clk_i);
        end
        stall_i = 1'b0;
    endtask

    // The redirect cycle itself must flush and fetch the word holding the new start
    task automatic run_redirect(input logic exc, input logic intr, input logic ret,
                                input logic redir, input fetch_addr_t target,
                                input fetch_addr_t expected_start, input bit random_stall);
        fetch_addr_t start_word;
        start_word = {expected_start[ADDR_WIDTH-1:2], 2'b00};
        @(negedge clk_i);
        handler_pc_i        = HANDLER_PC;
        handler_return_pc_i = RETURN_PC;
        redirect_target_i   = target;
        exception_i         = exc;
        interrupt_i         = intr;
        handler_return_i    = ret;
        redirect_i          = redir;
        build_expected_stream(expected_start);
        #1;
        check_value("invalidate on redirect", 32'(invalidate_o), 32'd1);
        check_value("fetch strobe on redirect", 32'(fetch_o), 32'd1);
        check_value("redirect fetch address", fetch_address_o, start_word);
        @(negedge clk_i);
        exception_i      = 1'b0;
        interrupt_i      = 1'b0;
        handler_return_i = 1'b0;
        redirect_i       = 1'b0;
        wait_stream(random_stall);
    endtask

    //==============================
    // Memory model and monitor
    //==============================

    // Answers in order after 1 to 3 cycles and drops everything pending on invalidate
    always @(negedge clk_i) begin
        fetch_valid_i = 1'b0;
        if (pend_addr.size() > 0 && pend_due[0] <= mem_cycle) begin
            fetch_valid_i       = 1'b1;
            fetch_instruction_i = memory_word(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        #1;
        if (!rst_n_i || invalidate_o) begin
            pend_addr.delete();
            pend_due.delete();
        end
        // The redirect fetch of a flush cycle is a new request and stays
        if (rst_n_i && fetch_o) begin
            pend_addr.push_back(fetch_address_o);
            pend_due.push_back(mem_cycle + 1 + (next_random() % MAX_DELAY));
        end
        mem_cycle++;
        if (mem_cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: the instruction stream did not finish in %0d cycles",
                     TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // One instruction is taken per cycle with valid high and no stall
    always @(negedge clk_i) begin
        #1;
        if (rst_n_i && tracking && instr_valid_o && !stall_i && !invalidate_o) begin
            check_value("instruction PC", instr_pc_o, exp_pc.pop_front());
            check_value("instruction word", instr_o, exp_instr.pop_front());
            check_value("compressed flag", 32'(instr_compressed_o),
                        32'(exp_compressed.pop_front()));
            if (exp_pc.size() == 0) begin
                tracking = 1'b0;
            end
        end
    end

    //==============================
    // Directed tests
    //==============================

    task automatic aligned_after_reset();
        mixed_mode = 1'b0;
        build_expected_stream(RESET_PC);
        rst_n_i = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        check_value("fetch strobe after reset", 32'(fetch_o), 32'd1);
        check_value("first fetch address", fetch_address_o, RESET_PC);
        check_value("valid after reset", 32'(instr_valid_o), 32'd0);
        check_value("invalidate after reset", 32'(invalidate_o), 32'd0);
        @(negedge clk_i);
        wait_stream(1'b0);
    endtask

    task automatic mixed_parcel_stream();
        mixed_mode = 1'b1;
        run_redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0100, 32'h0000_0100, 1'b0);
    endtask

    task automatic random_back_pressure();
        mixed_mode = 1'b1;
        run_redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0200, 32'h0000_0200, 1'b1);
    endtask

    // Handler entry beats handler return, which beats a plain redirect
    task automatic redirect_priority();
        run_redirect(1'b1, 1'b0, 1'b0, 1'b1, 32'h0000_0300, HANDLER_PC, 1'b0);
        run_redirect(1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_0300, HANDLER_PC, 1'b0);
        run_redirect(1'b0, 1'b0, 1'b1, 1'b1, 32'h0000_0300, RETURN_PC, 1'b0);
        run_redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0300, 32'h0000_0300, 1'b0);
    endtask

    task automatic halfword_redirect();
        fetch_addr_t target;
        target = find_halfword_target(32'h0000_0400, 1'b0);
        run_redirect(1'b0, 1'b0, 1'b0, 1'b1, target, target, 1'b0);
        target = find_halfword_target(32'h0000_0500, 1'b1);
        run_redirect(1'b0, 1'b0, 1'b0, 1'b1, target, target, 1'b1);
    endtask

    initial begin
        clk_i               = 1'b0;
        rst_n_i             = 1'b0;
        exception_i         = 1'b0;
        interrupt_i         = 1'b0;
        handler_pc_i        = '0;
        handler_return_i    = 1'b0;
        handler_return_pc_i = '0;
        redirect_i          = 1'b0;
        redirect_target_i   = '0;
        stall_i             = 1'b0;
        fetch_valid_i       = 1'b0;
        fetch_instruction_i = '0;
        rng_state           = SEED;
        mixed_mode          = 1'b0;
        tracking            = 1'b0;
        mem_cycle           = 0;
        aligned_after_reset();
        mixed_parcel_stream();
        random_back_pressure();
        redirect_priority();
        halfword_redirect();
        $display("TESTS PASSED");
        $finish;
    end

endmodule : tb_fetch_front_end

`default_nettype wire
